//--- logic/predecode_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_isa_consts.svh"

module predecode_select (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     valid_i,
    input  rv_predecode_pkg::instr_t raw_i,
    input  rv_predecode_pkg::instr_t expanded_i,
    input  logic                     rvc_illegal_i,
    input  logic                     base_illegal_i,
    output logic                     valid_o,
    output rv_predecode_pkg::instr_t instr_o,
    output logic                     compressed_o,
    output logic                     illegal_o
);

    import rv_predecode_pkg::*;

    logic   is_full;
    instr_t sel_instr;
    logic   sel_illegal;

    // ------------------------------------------------------------
    // path choice on the low two bits
    // ------------------------------------------------------------
    assign is_full     = (raw_i[1:0] == `RV_QUAD_FULL);
    assign sel_instr   = is_full ? raw_i : expanded_i;
    assign sel_illegal = is_full ? base_illegal_i : rvc_illegal_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            illegal_o <= 1'b0;
            instr_o   <= '0;
        end else begin
            valid_o <= valid_i;                    // one cycle behind fetch
            if (valid_i) begin
                instr_o   <= sel_instr;
                illegal_o <= sel_illegal;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            compressed_o <= !is_full;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv32_legality_check.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_legality_check (
    input  rv_predecode_pkg::instr_t instr_i,
    output logic                     illegal_o
);

    import rv_predecode_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ------------------------------------------------------------
    // per-opcode legality
    // ------------------------------------------------------------
    always_comb begin
        illegal_o = 1'b0;

        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_MISC_MEM, OPC_SYSTEM: begin
                illegal_o = 1'b0;                  // no sub-field checks
            end
            OPC_JALR: begin
                illegal_o = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                illegal_o = (funct3[2:1] == 2'b01);   // 010 and 011 unused
            end
            OPC_LOAD: begin
                illegal_o = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OPC_STORE: begin
                illegal_o = (funct3 > 3'b010);
            end
            OPC_OP: begin
                case (funct7)
                    7'b0000000: illegal_o = 1'b0;
                    7'b0100000: illegal_o = !((funct3 == 3'b000) || (funct3 == 3'b101));
                    default:    illegal_o = 1'b1;  // mul/div not supported
                endcase
            end
            OPC_OP_IMM: begin
                // only the shifts carry a funct7 field
                case (funct3)
                    3'b001:  illegal_o = (funct7 != 7'b0000000);
                    3'b101:  illegal_o = (funct7 != 7'b0000000) &&
                                         (funct7 != 7'b0100000);
                    default: illegal_o = 1'b0;
                endcase
            end
            default: begin
                illegal_o = 1'b1;                  // opcode outside the base set
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_isa_consts.svh
`ifndef RV_ISA_CONSTS_SVH
`define RV_ISA_CONSTS_SVH

// ------------------------------------------------------------
// base major opcodes
// ------------------------------------------------------------
`define RV_OPC_LOAD     7'b0000011
`define RV_OPC_STORE    7'b0100011
`define RV_OPC_OP_IMM   7'b0010011
`define RV_OPC_OP       7'b0110011
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_AUIPC    7'b0010111
`define RV_OPC_JAL      7'b1101111
`define RV_OPC_JALR     7'b1100111
`define RV_OPC_BRANCH   7'b1100011
`define RV_OPC_MISC_MEM 7'b0001111
`define RV_OPC_SYSTEM   7'b1110011

// ------------------------------------------------------------
// compressed quadrants and funct3 codes
// ------------------------------------------------------------
`define RVC_Q0          2'b00
`define RVC_Q1          2'b01
`define RVC_Q2          2'b10
`define RV_QUAD_FULL    2'b11    // low bits of a 32-bit word

`define RVC_F3_ADDI4SPN 3'b000   // q0
`define RVC_F3_LW       3'b010   // q0
`define RVC_F3_SW       3'b110   // q0
`define RVC_F3_ADDI     3'b000   // q1, also c.nop
`define RVC_F3_JAL      3'b001   // q1
`define RVC_F3_LI       3'b010   // q1
`define RVC_F3_LUI      3'b011   // q1, shared with c.addi16sp
`define RVC_F3_MISC_ALU 3'b100   // q1
`define RVC_F3_J        3'b101   // q1
`define RVC_F3_BEQZ     3'b110   // q1
`define RVC_F3_BNEZ     3'b111   // q1
`define RVC_F3_SLLI     3'b000   // q2
`define RVC_F3_LWSP     3'b010   // q2
`define RVC_F3_JR_ADD   3'b100   // q2, jr/mv/jalr/add/ebreak
`define RVC_F3_SWSP     3'b110   // q2

`define RV_REG_X0       5'd0
`define RV_REG_X1       5'd1     // link register
`define RV_REG_X2       5'd2     // stack pointer

`endif

//--- logic/rv_predecode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_predecode (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     fetch_valid_i,
    input  rv_predecode_pkg::instr_t fetch_word_i,
    output logic                     valid_o,
    output rv_predecode_pkg::instr_t instr_o,
    output logic                     compressed_o,
    output logic                     illegal_o
);

    import rv_predecode_pkg::*;

    instr_t expanded;
    logic   rvc_illegal;
    logic   base_illegal;

    // ------------------------------------------------------------
    // both paths see every word, select picks one
    // ------------------------------------------------------------
    rvc_expander rvc_expander_inst (
        .c_instr_i (fetch_word_i[15:0]),
        .instr_o   (expanded),
        .illegal_o (rvc_illegal)
    );

    rv32_legality_check rv32_legality_check_inst (
        .instr_i   (fetch_word_i),
        .illegal_o (base_illegal)
    );

    predecode_select predecode_select_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (fetch_valid_i),
        .raw_i          (fetch_word_i),
        .expanded_i     (expanded),
        .rvc_illegal_i  (rvc_illegal),
        .base_illegal_i (base_illegal),
        .valid_o        (valid_o),
        .instr_o        (instr_o),
        .compressed_o   (compressed_o),
        .illegal_o      (illegal_o)
    );

endmodule

`default_nettype wire

//--- logic/rv_predecode_pkg.sv
`default_nettype none

`include "rv_isa_consts.svh"

package rv_predecode_pkg;

    // ------------------------------------------------------------
    // instruction word and major opcodes
    // ------------------------------------------------------------
    typedef logic [31:0] instr_t;

    typedef enum logic [6:0] {
        OPC_LOAD     = `RV_OPC_LOAD,
        OPC_STORE    = `RV_OPC_STORE,
        OPC_OP_IMM   = `RV_OPC_OP_IMM,
        OPC_OP       = `RV_OPC_OP,
        OPC_LUI      = `RV_OPC_LUI,
        OPC_AUIPC    = `RV_OPC_AUIPC,
        OPC_JAL      = `RV_OPC_JAL,
        OPC_JALR     = `RV_OPC_JALR,
        OPC_BRANCH   = `RV_OPC_BRANCH,
        OPC_MISC_MEM = `RV_OPC_MISC_MEM,   // fence
        OPC_SYSTEM   = `RV_OPC_SYSTEM      // ecall, ebreak
    } opcode_t;

endpackage

`default_nettype wire

//--- logic/rvc_expander.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_isa_consts.svh"

module rvc_expander (
    input  logic [15:0]              c_instr_i,
    output rv_predecode_pkg::instr_t instr_o,
    output logic                     illegal_o
);

    import rv_predecode_pkg::*;

    // ------------------------------------------------------------
    // compressed fields
    // ------------------------------------------------------------
    logic [15:0] c;
    logic [1:0]  quad;
    logic [2:0]  funct3;
    logic [4:0]  rd;       // rd and rs1 share bits 11:7
    logic [4:0]  rs2;
    logic [4:0]  rp_lo;    // rd' / rs2', x8..x15
    logic [4:0]  rp_hi;    // rs1' / rd', x8..x15

    assign c      = c_instr_i;
    assign quad   = c[1:0];
    assign funct3 = c[15:13];
    assign rd     = c[11:7];
    assign rs2    = c[6:2];
    assign rp_lo  = {2'b01, c[4:2]};
    assign rp_hi  = {2'b01, c[9:7]};

    // ------------------------------------------------------------
    // expansion
    // ------------------------------------------------------------
    always_comb begin
        instr_o   = '0;
        illegal_o = 1'b0;

        case ({funct3, quad})
            {`RVC_F3_ADDI4SPN, `RVC_Q0}: begin     // addi rd', x2, nzuimm
                illegal_o = (c[12:5] == 8'd0);
                instr_o   = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                             `RV_REG_X2, 3'b000, rp_lo, OPC_OP_IMM};
            end
            {`RVC_F3_LW, `RVC_Q0}: begin           // lw rd', uimm(rs1')
                instr_o = {5'b00000, c[5], c[12:10], c[6], 2'b00,
                           rp_hi, 3'b010, rp_lo, OPC_LOAD};
            end
            {`RVC_F3_SW, `RVC_Q0}: begin           // sw rs2', uimm(rs1')
                instr_o = {5'b00000, c[5], c[12], rp_lo, rp_hi, 3'b010,
                           c[11:10], c[6], 2'b00, OPC_STORE};
            end

            {`RVC_F3_ADDI, `RVC_Q1}: begin         // addi rd, rd, imm, nop when rd is x0
                instr_o = {{7{c[12]}}, c[6:2], rd, 3'b000, rd, OPC_OP_IMM};
            end
            {`RVC_F3_JAL, `RVC_Q1}: begin          // jal x1, offset
                instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                           {9{c[12]}}, `RV_REG_X1, OPC_JAL};
            end
            {`RVC_F3_LI, `RVC_Q1}: begin           // addi rd, x0, imm
                instr_o = {{7{c[12]}}, c[6:2], `RV_REG_X0, 3'b000, rd, OPC_OP_IMM};
            end
            {`RVC_F3_LUI, `RVC_Q1}: begin
                // zero immediate is reserved for both addi16sp and lui
                illegal_o = ({c[12], c[6:2]} == 6'd0);
                if (rd == `RV_REG_X2) begin
                    instr_o = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                               `RV_REG_X2, 3'b000, `RV_REG_X2, OPC_OP_IMM};
                end else begin
                    instr_o = {{15{c[12]}}, c[6:2], rd, OPC_LUI};
                end
            end
            {`RVC_F3_MISC_ALU, `RVC_Q1}: begin
                case (c[11:10])
                    2'b00: begin                   // srli
                        illegal_o = c[12];         // shamt[5] is rv64 only
                        instr_o   = {7'b0000000, c[6:2], rp_hi, 3'b101, rp_hi, OPC_OP_IMM};
                    end
                    2'b01: begin                   // srai
                        illegal_o = c[12];
                        instr_o   = {7'b0100000, c[6:2], rp_hi, 3'b101, rp_hi, OPC_OP_IMM};
                    end
                    2'b10: begin                   // andi
                        instr_o = {{7{c[12]}}, c[6:2], rp_hi, 3'b111, rp_hi, OPC_OP_IMM};
                    end
                    default: begin
                        if (c[12]) begin
                            illegal_o = 1'b1;      // subw/addw and reserved
                        end else begin
                            case (c[6:5])
                                2'b00:   instr_o = {7'b0100000, rp_lo, rp_hi, 3'b000,
                                                    rp_hi, OPC_OP};
                                2'b01:   instr_o = {7'b0000000, rp_lo, rp_hi, 3'b100,
                                                    rp_hi, OPC_OP};
                                2'b10:   instr_o = {7'b0000000, rp_lo, rp_hi, 3'b110,
                                                    rp_hi, OPC_OP};
                                default: instr_o = {7'b0000000, rp_lo, rp_hi, 3'b111,
                                                    rp_hi, OPC_OP};
                            endcase
                        end
                    end
                endcase
            end
            {`RVC_F3_J, `RVC_Q1}: begin            // jal x0, offset
                instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                           {9{c[12]}}, `RV_REG_X0, OPC_JAL};
            end
            {`RVC_F3_BEQZ, `RVC_Q1}: begin         // beq rs1', x0, offset
                instr_o = {{4{c[12]}}, c[6:5], c[2], `RV_REG_X0, rp_hi, 3'b000,
                           c[11:10], c[4:3], c[12], OPC_BRANCH};
            end
            {`RVC_F3_BNEZ, `RVC_Q1}: begin         // bne rs1', x0, offset
                instr_o = {{4{c[12]}}, c[6:5], c[2], `RV_REG_X0, rp_hi, 3'b001,
                           c[11:10], c[4:3], c[12], OPC_BRANCH};
            end

            {`RVC_F3_SLLI, `RVC_Q2}: begin         // slli rd, rd, shamt
                illegal_o = c[12];
                instr_o   = {7'b0000000, c[6:2], rd, 3'b001, rd, OPC_OP_IMM};
            end
            {`RVC_F3_LWSP, `RVC_Q2}: begin         // lw rd, uimm(x2)
                illegal_o = (rd == `RV_REG_X0);
                instr_o   = {4'b0000, c[3:2], c[12], c[6:4], 2'b00,
                             `RV_REG_X2, 3'b010, rd, OPC_LOAD};
            end
            {`RVC_F3_JR_ADD, `RVC_Q2}: begin
                if (!c[12]) begin
                    if (rs2 == `RV_REG_X0) begin   // jr rs1
                        illegal_o = (rd == `RV_REG_X0);
                        instr_o   = {12'd0, rd, 3'b000, `RV_REG_X0, OPC_JALR};
                    end else begin                 // mv, add rd, x0, rs2
                        instr_o = {7'b0000000, rs2, `RV_REG_X0, 3'b000, rd, OPC_OP};
                    end
                end else if (rs2 != `RV_REG_X0) begin      // add rd, rd, rs2
                    instr_o = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};
                end else if (rd != `RV_REG_X0) begin       // jalr x1, rs1
                    instr_o = {12'd0, rd, 3'b000, `RV_REG_X1, OPC_JALR};
                end else begin
                    illegal_o = 1'b1;              // c.ebreak not supported here
                end
            end
            {`RVC_F3_SWSP, `RVC_Q2}: begin         // sw rs2, uimm(x2)
                instr_o = {4'b0000, c[8:7], c[12], rs2, `RV_REG_X2, 3'b010,
                           c[11:9], 2'b00, OPC_STORE};
            end

            default: begin
                illegal_o = 1'b1;                  // fp forms and reserved slots
            end
        endcase
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the predecode testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module rv_predecode_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if ! grep -q "test passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

//--- src.f
+incdir+logic
logic/rv_predecode_pkg.sv
logic/rvc_expander.sv
logic/rv32_legality_check.sv
logic/predecode_select.sv
logic/rv_predecode.sv
tests/rv_predecode_tb.sv

//--- tests/rv_predecode_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_isa_consts.svh"

module rv_predecode_tb;

    import rv_predecode_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;   // about twice the directed sequence
    localparam int N_LEGAL = 40;
    localparam int N_BAD   = 5;
    localparam int N_RVC   = 26;
    localparam int N_RSV   = 7;

    // one example per opcode and legal funct3/funct7 form
    localparam instr_t LEGAL_WORDS [N_LEGAL] = '{
        32'h000017B7, 32'h00000097, 32'h008000EF, 32'h00008067,
        32'h00000063, 32'h00001063, 32'h00004063, 32'h00005063,
        32'h00006063, 32'h00007063, 32'h00000003, 32'h00001003,
        32'h00452483, 32'h00004003, 32'h00005003, 32'h00000023,
        32'h00001023, 32'h00952023, 32'hFFF50513, 32'h00002013,
        32'h00429293, 32'h00345413, 32'h4024D493, 32'hFFE57513,
        32'h00B50533, 32'h40940433, 32'h00001033, 32'h00002033,
        32'h00A4C4B3, 32'h00005033, 32'h40005033, 32'h00C5F5B3,
        32'h0FF0000F, 32'h00000073, 32'h00100073, 32'h00003013,
        32'h00004013, 32'h00006013, 32'h00003033, 32'h00006033
    };

    // unlisted opcode, jalr f3 001, branch f3 010, load f3 111, op f7 0000001
    localparam instr_t BAD_WORDS [N_BAD] = '{
        32'h0000007B, 32'h00009067, 32'h00002063, 32'h00007003, 32'h02000033
    };

    // addi4spn lw sw nop addi jal li addi16sp lui srli srai andi sub
    // xor or and j beqz bnez slli lwsp jr mv jalr add swsp
    localparam logic [15:0] RVC_HALF [N_RVC] = '{
        16'h0040, 16'h4144, 16'hC104, 16'h0001, 16'h157D, 16'h2021,
        16'h4595, 16'h717D, 16'h6785, 16'h800D, 16'h8489, 16'h9979,
        16'h8C05, 16'h8CA9, 16'h8D4D, 16'h8DF1, 16'hBFFD, 16'hDC75,
        16'hE099, 16'h0292, 16'h4322, 16'h8082, 16'h852E, 16'h9282,
        16'h952E, 16'hC622
    };

    localparam instr_t RVC_FULL [N_RVC] = '{
        32'h00410413, 32'h00452483, 32'h00952023, 32'h00000013,
        32'hFFF50513, 32'h008000EF, 32'h00500593, 32'hFF010113,
        32'h000017B7, 32'h00345413, 32'h4024D493, 32'hFFE57513,
        32'h40940433, 32'h00A4C4B3, 32'h00B56533, 32'h00C5F5B3,
        32'hFFFFF06F, 32'hFE040EE3, 32'h00049363, 32'h00429293,
        32'h00812303, 32'h00008067, 32'h00B00533, 32'h000280E7,
        32'h00B50533, 32'h00812623
    };

    // zero word, addi4spn imm 0, lui imm 0, lwsp rd 0, jr x0, srli shamt[5], q0 f3 001
    localparam logic [15:0] RSV_HALF [N_RSV] = '{
        16'h0000, 16'h0004, 16'h6781, 16'h4002, 16'h8002, 16'h9001, 16'h2000
    };

    localparam logic [6:0] OPC_LIST [11] = '{
        `RV_OPC_LOAD, `RV_OPC_STORE, `RV_OPC_OP_IMM, `RV_OPC_OP, `RV_OPC_LUI,
        `RV_OPC_AUIPC, `RV_OPC_JAL, `RV_OPC_JALR, `RV_OPC_BRANCH,
        `RV_OPC_MISC_MEM, `RV_OPC_SYSTEM
    };

    logic   clk;
    logic   rst_n_i;
    logic   fetch_valid_i;
    instr_t fetch_word_i;
    logic   valid_o;
    instr_t instr_o;
    logic   compressed_o;
    logic   illegal_o;
    integer seed;
    int     cycles;

    rv_predecode rv_predecode_inst (
        .clk_i         (clk),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_word_i  (fetch_word_i),
        .valid_o       (valid_o),
        .instr_o       (instr_o),
        .compressed_o  (compressed_o),
        .illegal_o     (illegal_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the test sequence did not finish within %0d cycles", cycles);
            $display("test failed");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    // ------------------------------------------------------------
    // reference rule and compare tasks
    // ------------------------------------------------------------
    function automatic logic expect_base_illegal(instr_t w);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        if (opc == `RV_OPC_LUI || opc == `RV_OPC_AUIPC || opc == `RV_OPC_JAL ||
            opc == `RV_OPC_MISC_MEM || opc == `RV_OPC_SYSTEM)
            return 1'b0;
        else if (opc == `RV_OPC_JALR)
            return f3 != 3'd0;
        else if (opc == `RV_OPC_BRANCH)
            return f3 == 3'd2 || f3 == 3'd3;
        else if (opc == `RV_OPC_LOAD)
            return f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7;
        else if (opc == `RV_OPC_STORE)
            return f3 > 3'd2;
        else if (opc == `RV_OPC_OP)
            return !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        else if (opc == `RV_OPC_OP_IMM && f3 == 3'd1)
            return f7 != 7'h00;
        else if (opc == `RV_OPC_OP_IMM && f3 == 3'd5)
            return !(f7 == 7'h00 || f7 == 7'h20);
        else if (opc == `RV_OPC_OP_IMM)
            return 1'b0;
        return 1'b1;                                // opcode not in the base set
    endfunction

    task automatic check_instr(instr_t got, instr_t want, string what);
        if (got !== want) begin
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, want);
            $display("test failed");
            $fatal(1, "instruction mismatch");
        end
    endtask

    task automatic check_flag(logic got, logic want, string what);
        if (got !== want) begin
            $display("error at %0t ns: %s got %b expected %b", $time, what, got, want);
            $display("test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // drive one valid word, then check the registered outputs one cycle later
    task automatic apply_word(instr_t word, instr_t want, logic want_c, logic want_ill);
        @(negedge clk);
        fetch_valid_i = 1'b1;
        fetch_word_i  = word;
        @(negedge clk);
        fetch_valid_i = 1'b0;
        check_flag(valid_o, 1'b1, "valid_o");
        check_instr(instr_o, want, "instr_o");
        check_flag(compressed_o, want_c, "compressed_o");
        check_flag(illegal_o, want_ill, "illegal_o");
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_reset();
        rst_n_i = 1'b0;
        repeat (4) @(negedge clk);
        check_flag(valid_o, 1'b0, "valid_o in reset");
        check_flag(illegal_o, 1'b0, "illegal_o in reset");
        check_instr(instr_o, '0, "instr_o in reset");
        rst_n_i = 1'b1;
        @(negedge clk);
        check_flag(valid_o, 1'b0, "valid_o after reset");
        check_flag(illegal_o, 1'b0, "illegal_o after reset");
        @(negedge clk);
        check_flag(valid_o, 1'b0, "valid_o with idle fetch");
    endtask

    task automatic test_base_words();
        foreach (LEGAL_WORDS[i])
            apply_word(LEGAL_WORDS[i], LEGAL_WORDS[i], 1'b0, 1'b0);
        foreach (BAD_WORDS[i])
            apply_word(BAD_WORDS[i], BAD_WORDS[i], 1'b0, 1'b1);
    endtask

    task automatic test_compressed();
        logic [31:0] r;
        foreach (RVC_HALF[i]) begin
            r = $random(seed);
            apply_word({r[31:16], RVC_HALF[i]}, RVC_FULL[i], 1'b1, 1'b0);
        end
    endtask

    task automatic test_reserved();
        logic [31:0] r;
        foreach (RSV_HALF[i]) begin
            r = $random(seed);
            @(negedge clk);
            fetch_valid_i = 1'b1;
            fetch_word_i  = {r[31:16], RSV_HALF[i]};
            @(negedge clk);
            fetch_valid_i = 1'b0;
            check_flag(valid_o, 1'b1, "valid_o reserved");
            check_flag(compressed_o, 1'b1, "compressed_o reserved");
            check_flag(illegal_o, 1'b1, "illegal_o reserved");
        end
    endtask

    // random base word forced onto a legal funct3/funct7 for its opcode
    function automatic instr_t make_legal_word(logic [31:0] r, logic [6:0] opc);
        instr_t w;
        w = {r[31:7], opc};
        if (opc == `RV_OPC_OP)
            w[31:25] = 7'h00;
        if (opc == `RV_OPC_OP_IMM && (w[14:12] == 3'd1 || w[14:12] == 3'd5))
            w[31:25] = 7'h00;
        if (opc == `RV_OPC_JALR)
            w[14:12] = 3'd0;
        if (opc == `RV_OPC_BRANCH && w[13] && !w[14])
            w[14] = 1'b1;
        if (opc == `RV_OPC_LOAD || opc == `RV_OPC_STORE)
            w[14:13] = 2'b00;
        return w;
    endfunction

    task automatic test_stream();
        logic [31:0] r;
        instr_t      word;
        instr_t      want;
        logic        want_c;
        logic        want_ill;
        logic        prev_valid;
        int          sent;
        int          step;
        prev_valid = 1'b0;
        sent = 0;
        step = 0;
        while (sent < 30 || prev_valid) begin
            @(negedge clk);
            if (prev_valid) begin
                check_flag(valid_o, 1'b1, "stream valid_o");
                check_instr(instr_o, want, "stream instr_o");
                check_flag(compressed_o, want_c, "stream compressed_o");
                check_flag(illegal_o, want_ill, "stream illegal_o");
            end else if (step > 0) begin
                check_flag(valid_o, 1'b0, "stream idle valid_o");
            end
            prev_valid = 1'b0;
            fetch_valid_i = 1'b0;
            if (sent < 30 && step % 7 != 4) begin    // an idle slot now and then
                r = $random(seed);
                if (sent % 2 == 0) begin
                    word     = make_legal_word(r, OPC_LIST[r[3:0] % 11]);
                    want     = word;
                    want_c   = 1'b0;
                    want_ill = expect_base_illegal(word);
                end else begin
                    word     = {r[31:16], RVC_HALF[(sent * 5) % N_RVC]};
                    want     = RVC_FULL[(sent * 5) % N_RVC];
                    want_c   = 1'b1;
                    want_ill = 1'b0;
                end
                fetch_valid_i = 1'b1;
                fetch_word_i  = word;
                prev_valid    = 1'b1;
                sent++;
            end
            step++;
        end
        fetch_valid_i = 1'b0;
    endtask

    // ------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------
    initial begin
        seed          = 32'h19fd_62d4;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_word_i  = '0;
        test_reset();
        test_base_words();
        test_compressed();
        test_reserved();
        test_stream();
        @(negedge clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
